// File: Bender.yml
package:
  name: riscv_core

sources:
  - core_pkg.sv
  - fetch_stage.sv
  - decode_stage.sv
  - execute_stage.sv
  - memory_stage.sv
  - hazard_unit.sv
  - riscv_core.sv
  - target: test
    files:
      - tb_riscv_core.sv

// File: compile.f
core_pkg.sv
fetch_stage.sv
decode_stage.sv
execute_stage.sv
memory_stage.sv
hazard_unit.sv
riscv_core.sv
tb_riscv_core.sv

// File: core_pkg.sv
package core_pkg;

  localparam int REG_AW = 5;                 // register index width

  typedef logic [REG_AW-1:0] reg_addr_t;

  // one 32-bit instruction word, read through its format views
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      reg_addr_t  rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;
      reg_addr_t   rs1;
      logic [2:0]  funct3;
      reg_addr_t   rd;
      logic [6:0]  opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;                    // imm[11:5]
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;                    // imm[4:0]
      logic [6:0] opcode;
    } s;
    struct packed {
      logic       imm12;                     // sign bit
      logic [5:0] imm10_5;
      reg_addr_t  rs2;
      reg_addr_t  rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } b;
  } inst_u;

  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;

  localparam logic [2:0] ALU_ADD  = 3'd0;
  localparam logic [2:0] ALU_SUB  = 3'd1;
  localparam logic [2:0] ALU_AND  = 3'd2;
  localparam logic [2:0] ALU_OR   = 3'd3;
  localparam logic [2:0] ALU_XOR  = 3'd4;
  localparam logic [2:0] ALU_SLT  = 3'd5;
  localparam logic [2:0] ALU_SLTU = 3'd6;

  localparam logic [1:0] FWD_NONE = 2'd0;    // register file value
  localparam logic [1:0] FWD_MEM  = 2'd1;    // alu value in memory stage
  localparam logic [1:0] FWD_WB   = 2'd2;    // writeback result

endpackage

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
  parameter int XLEN = 64
) (
  input  logic                i_decode_stage_clk,
  input  logic                i_rst_n,
  input  logic                i_stall_d,
  input  logic                i_flush_e,
  input  core_pkg::inst_u     i_inst_d,
  input  logic [XLEN-1:0]     i_pc_d,
  input  logic                i_regw_w,
  input  core_pkg::reg_addr_t i_rd_w,
  input  logic [XLEN-1:0]     i_result_w,
  output core_pkg::reg_addr_t o_rs1_d,
  output core_pkg::reg_addr_t o_rs2_d,
  output core_pkg::reg_addr_t o_rs1_e,
  output core_pkg::reg_addr_t o_rs2_e,
  output core_pkg::reg_addr_t o_rd_e,
  output logic [XLEN-1:0]     o_rdata1_e,
  output logic [XLEN-1:0]     o_rdata2_e,
  output logic [XLEN-1:0]     o_imm_e,
  output logic [XLEN-1:0]     o_pc_e,
  output logic [2:0]          o_aluop_e,
  output logic                o_bsel_e,
  output logic                o_regw_e,
  output logic                o_memr_e,
  output logic                o_memw_e,
  output logic                o_branch_e,
  output logic                o_bne_e
);
  import core_pkg::*;

  logic [XLEN-1:0] regs [32];
  logic [XLEN-1:0] rdata1;
  logic [XLEN-1:0] rdata2;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_s;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm;
  logic [2:0]      aluop;
  logic            bsel;
  logic            regw;
  logic            memr;
  logic            memw;
  logic            branch;
  logic            use_rs2;

  assign imm_i = {{(XLEN-12){i_inst_d.i.imm12[11]}}, i_inst_d.i.imm12};
  assign imm_s = {{(XLEN-12){i_inst_d.s.imm_hi[6]}}, i_inst_d.s.imm_hi, i_inst_d.s.imm_lo};
  assign imm_b = {{(XLEN-12){i_inst_d.b.imm12}}, i_inst_d.b.imm11, i_inst_d.b.imm10_5,
                  i_inst_d.b.imm4_1, 1'b0};

  always_comb begin
    aluop   = ALU_ADD;
    imm     = imm_i;
    bsel    = 1'b0;
    regw    = 1'b0;
    memr    = 1'b0;
    memw    = 1'b0;
    branch  = 1'b0;
    use_rs2 = 1'b0;
    case (i_inst_d.r.opcode)
      OP_REG, OP_IMM: begin
        bsel    = (i_inst_d.r.opcode == OP_IMM);
        use_rs2 = !bsel;
        regw    = 1'b1;
        case (i_inst_d.r.funct3)
          3'b000:  aluop = (!bsel && i_inst_d.r.funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b010:  aluop = ALU_SLT;
          3'b011:  aluop = ALU_SLTU;
          3'b100:  aluop = ALU_XOR;
          3'b110:  aluop = ALU_OR;
          3'b111:  aluop = ALU_AND;
          default: regw  = 1'b0;                    // shifts fall through as no-ops
        endcase
      end
      OP_LOAD: begin
        bsel = 1'b1;
        regw = 1'b1;
        memr = 1'b1;
      end
      OP_STORE: begin
        imm     = imm_s;
        bsel    = 1'b1;
        memw    = 1'b1;
        use_rs2 = 1'b1;
      end
      OP_BRANCH: begin
        imm     = imm_b;
        use_rs2 = 1'b1;
        branch  = (i_inst_d.b.funct3[2:1] == 2'b00); // beq and bne only
      end
      default: ;
    endcase
  end

  assign o_rs1_d = i_inst_d.r.rs1;
  assign o_rs2_d = use_rs2 ? i_inst_d.r.rs2 : '0;  // keeps immediates out of hazard checks

  // x0 reads zero and a write in this cycle is seen at once
  assign rdata1 = (o_rs1_d == '0) ? '0 :
                  (i_regw_w && i_rd_w == o_rs1_d) ? i_result_w : regs[o_rs1_d];
  assign rdata2 = (o_rs2_d == '0) ? '0 :
                  (i_regw_w && i_rd_w == o_rs2_d) ? i_result_w : regs[o_rs2_d];

  always_ff @(posedge i_decode_stage_clk) begin
    if (i_regw_w && i_rd_w != '0) regs[i_rd_w] <= i_result_w;
  end

  always_ff @(posedge i_decode_stage_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_aluop_e  <= ALU_ADD;
      o_bsel_e   <= 1'b0;
      o_regw_e   <= 1'b0;
      o_memr_e   <= 1'b0;
      o_memw_e   <= 1'b0;
      o_branch_e <= 1'b0;
      o_bne_e    <= 1'b0;
    end else if (i_flush_e) begin
      o_aluop_e  <= ALU_ADD;
      o_bsel_e   <= 1'b0;
      o_regw_e   <= 1'b0;
      o_memr_e   <= 1'b0;
      o_memw_e   <= 1'b0;
      o_branch_e <= 1'b0;
      o_bne_e    <= 1'b0;
    end else if (!i_stall_d) begin
      o_aluop_e  <= aluop;
      o_bsel_e   <= bsel;
      o_regw_e   <= regw;
      o_memr_e   <= memr;
      o_memw_e   <= memw;
      o_branch_e <= branch;
      o_bne_e    <= i_inst_d.b.funct3[0];
    end
  end

  always_ff @(posedge i_decode_stage_clk) begin
    if (!i_stall_d) begin
      o_rs1_e    <= o_rs1_d;
      o_rs2_e    <= o_rs2_d;
      o_rd_e     <= i_inst_d.r.rd;
      o_rdata1_e <= rdata1;
      o_rdata2_e <= rdata2;
      o_imm_e    <= imm;
      o_pc_e     <= i_pc_d;
    end
  end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
  parameter int XLEN = 64
) (
  input  logic                i_execute_stage_clk,
  input  logic                i_rst_n,
  input  logic                i_globstall,
  input  core_pkg::reg_addr_t i_rs1_e,
  input  core_pkg::reg_addr_t i_rs2_e,
  input  core_pkg::reg_addr_t i_rd_e,
  input  logic [XLEN-1:0]     i_rdata1_e,
  input  logic [XLEN-1:0]     i_rdata2_e,
  input  logic [XLEN-1:0]     i_imm_e,
  input  logic [XLEN-1:0]     i_pc_e,
  input  logic [2:0]          i_aluop_e,
  input  logic                i_bsel_e,
  input  logic                i_regw_e,
  input  logic                i_memr_e,
  input  logic                i_memw_e,
  input  logic                i_branch_e,
  input  logic                i_bne_e,
  input  logic [1:0]          i_fwd_a,
  input  logic [1:0]          i_fwd_b,
  input  logic [XLEN-1:0]     i_result_w,
  output logic                o_pcsrc_e,
  output logic [XLEN-1:0]     o_target_e,
  output logic [XLEN-1:0]     o_alu_m,
  output logic [XLEN-1:0]     o_store_m,
  output core_pkg::reg_addr_t o_rd_m,
  output logic                o_regw_m,
  output logic                o_memr_m,
  output logic                o_memw_m
);
  import core_pkg::*;

  logic [XLEN-1:0] src_a;
  logic [XLEN-1:0] rs2_val;
  logic [XLEN-1:0] src_b;
  logic [XLEN-1:0] alu_y;

  function automatic logic [XLEN-1:0] fwd_mux(logic [1:0] sel, logic [XLEN-1:0] reg_val,
                                              logic [XLEN-1:0] mem_val,
                                              logic [XLEN-1:0] wb_val);
    case (sel)
      FWD_MEM: return mem_val;
      FWD_WB:  return wb_val;
      default: return reg_val;
    endcase
  endfunction

  assign src_a   = fwd_mux(i_fwd_a, i_rdata1_e, o_alu_m, i_result_w);
  assign rs2_val = fwd_mux(i_fwd_b, i_rdata2_e, o_alu_m, i_result_w);
  assign src_b   = i_bsel_e ? i_imm_e : rs2_val;

  always_comb begin
    case (i_aluop_e)
      ALU_SUB:  alu_y = src_a - src_b;
      ALU_AND:  alu_y = src_a & src_b;
      ALU_OR:   alu_y = src_a | src_b;
      ALU_XOR:  alu_y = src_a ^ src_b;
      ALU_SLT:  alu_y = XLEN'($signed(src_a) < $signed(src_b));
      ALU_SLTU: alu_y = XLEN'(src_a < src_b);
      default:  alu_y = src_a + src_b;
    endcase
  end

  // beq takes on equal, bne on not equal
  assign o_pcsrc_e  = i_branch_e && ((src_a == rs2_val) ^ i_bne_e);
  assign o_target_e = i_pc_e + i_imm_e;

  always_ff @(posedge i_execute_stage_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_regw_m <= 1'b0;
      o_memr_m <= 1'b0;
      o_memw_m <= 1'b0;
    end else if (!i_globstall) begin
      o_regw_m <= i_regw_e;
      o_memr_m <= i_memr_e;
      o_memw_m <= i_memw_e;
    end
  end

  always_ff @(posedge i_execute_stage_clk) begin
    if (!i_globstall) begin
      o_alu_m   <= alu_y;
      o_store_m <= rs2_val;                         // forwarded store data
      o_rd_m    <= i_rd_e;
    end
  end

endmodule

// File: fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            i_fetch_stage_clk,
  input  logic            i_rst_n,
  input  logic            i_stall_f,
  input  logic            i_stall_d,
  input  logic            i_flush_d,
  input  logic            i_pcsrc_e,
  input  logic [XLEN-1:0] i_target_e,
  input  core_pkg::inst_u i_inst,
  output logic [XLEN-1:0] o_pc,
  output core_pkg::inst_u o_inst_d,
  output logic [XLEN-1:0] o_pc_d
);

  localparam logic [31:0] NOP = 32'h0000_0013;   // addi x0, x0, 0

  logic [XLEN-1:0] pc_next;

  assign pc_next = i_pcsrc_e ? i_target_e : o_pc + XLEN'(4);

  always_ff @(posedge i_fetch_stage_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_pc     <= RESET_PC;
      o_inst_d <= NOP;
    end else begin
      if (!i_stall_f) o_pc <= pc_next;
      if (i_flush_d) o_inst_d <= NOP;               // squash wrong-path fetch
      else if (!i_stall_d) o_inst_d <= i_inst;
    end
  end

  always_ff @(posedge i_fetch_stage_clk) begin
    if (!i_stall_d) o_pc_d <= o_pc;
  end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  logic                i_hazard_unit_clk,
  input  core_pkg::reg_addr_t i_rs1_d,
  input  core_pkg::reg_addr_t i_rs2_d,
  input  core_pkg::reg_addr_t i_rs1_e,
  input  core_pkg::reg_addr_t i_rs2_e,
  input  core_pkg::reg_addr_t i_rd_e,
  input  core_pkg::reg_addr_t i_rd_m,
  input  core_pkg::reg_addr_t i_rd_w,
  input  logic                i_memr_e,
  input  logic                i_regw_m,
  input  logic                i_regw_w,
  input  logic                i_pcsrc_e,
  input  logic                i_stall_dm,
  output logic [1:0]          o_fwd_a,
  output logic [1:0]          o_fwd_b,
  output logic                o_stall_f,
  output logic                o_stall_d,
  output logic                o_flush_d,
  output logic                o_flush_e,
  output logic                o_globstall
);
  import core_pkg::*;

  logic lu_stall;

  // memory stage wins over writeback and x0 is never forwarded
  function automatic logic [1:0] fwd_sel(reg_addr_t rs);
    if (i_regw_m && i_rd_m != '0 && i_rd_m == rs) return FWD_MEM;
    if (i_regw_w && i_rd_w != '0 && i_rd_w == rs) return FWD_WB;
    return FWD_NONE;
  endfunction

  always_comb begin
    o_fwd_a = fwd_sel(i_rs1_e);
    o_fwd_b = fwd_sel(i_rs2_e);
  end

  assign lu_stall    = i_memr_e && i_rd_e != '0 && (i_rd_e == i_rs1_d || i_rd_e == i_rs2_d);
  assign o_globstall = i_stall_dm;
  assign o_stall_f   = lu_stall || i_stall_dm;
  assign o_stall_d   = lu_stall || i_stall_dm;
  assign o_flush_d   = i_pcsrc_e && !i_stall_dm;                // frozen pipe keeps its slots
  assign o_flush_e   = (i_pcsrc_e || lu_stall) && !i_stall_dm;  // bubble behind the load

  // the load moves on after one bubble unless memory holds everything
  lu_once_a: assert property (@(posedge i_hazard_unit_clk)
    lu_stall && !i_stall_dm |=> !lu_stall)
    else $error("load-use stall longer than one cycle");

endmodule

// File: memory_stage.sv
`timescale 1ns/1ps

module memory_stage #(
  parameter int XLEN = 64
) (
  input  logic                i_memory_stage_clk,
  input  logic                i_rst_n,
  input  logic                i_globstall,
  input  logic                i_memr_m,
  input  logic                i_memw_m,
  input  logic                i_regw_m,
  input  logic [XLEN-1:0]     i_alu_m,
  input  logic [XLEN-1:0]     i_store_m,
  input  logic [XLEN-1:0]     i_rdata,
  input  core_pkg::reg_addr_t i_rd_m,
  output logic [XLEN-1:0]     o_mem_addr,
  output logic [XLEN-1:0]     o_store_data,
  output logic                o_memr,
  output logic                o_memw,
  output logic                o_regw_w,
  output core_pkg::reg_addr_t o_rd_w,
  output logic [XLEN-1:0]     o_result_w
);

  logic [XLEN-1:0] result_m;

  assign o_mem_addr   = i_alu_m;
  assign o_store_data = i_store_m;
  assign o_memr       = i_memr_m;
  assign o_memw       = i_memw_m;
  assign result_m     = i_memr_m ? i_rdata : i_alu_m;   // load data or alu value

  always_ff @(posedge i_memory_stage_clk or negedge i_rst_n) begin
    if (!i_rst_n) o_regw_w <= 1'b0;
    else if (!i_globstall) o_regw_w <= i_regw_m;
  end

  always_ff @(posedge i_memory_stage_clk) begin
    if (!i_globstall) begin
      o_rd_w     <= i_rd_m;
      o_result_w <= result_m;
    end
  end

  mem_excl_a: assert property (@(posedge i_memory_stage_clk) disable iff (!i_rst_n)
    !(o_memr && o_memw))
    else $error("data memory read and write requested together");

  // a stalled request must not move until the memory lets it complete
  mem_hold_a: assert property (@(posedge i_memory_stage_clk) disable iff (!i_rst_n)
    i_globstall && (o_memr || o_memw) |=>
      $stable(o_mem_addr) && $stable(o_store_data) && $stable(o_memr) && $stable(o_memw))
    else $error("data memory request changed while stalled");

endmodule

// File: riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
  parameter int              XLEN     = 64,
  parameter logic [XLEN-1:0] RESET_PC = '0
) (
  input  logic            i_riscv_core_clk,
  input  logic            i_rst_n,
  input  core_pkg::inst_u i_inst,
  input  logic [XLEN-1:0] i_rdata,
  input  logic            i_stall_dm,
  output logic [XLEN-1:0] o_pc,
  output logic            o_memr_m,
  output logic            o_memw_m,
  output logic [XLEN-1:0] o_mem_addr,
  output logic [XLEN-1:0] o_store_data,
  output logic            o_globstall
);
  import core_pkg::*;

  logic            stall_f, stall_d, flush_d, flush_e;   // hazard controls
  logic [1:0]      fwd_a, fwd_b;
  logic            pcsrc_e;
  logic [XLEN-1:0] target_e;
  inst_u           inst_d;
  logic [XLEN-1:0] pc_d;
  reg_addr_t       rs1_d, rs2_d, rs1_e, rs2_e, rd_e, rd_m, rd_w;
  logic [XLEN-1:0] rdata1_e, rdata2_e, imm_e, pc_e;
  logic [2:0]      aluop_e;
  logic            bsel_e, regw_e, memr_e, memw_e, branch_e, bne_e;
  logic [XLEN-1:0] alu_m, store_m, result_w;
  logic            regw_m, memr_m, memw_m, regw_w;

  fetch_stage #(.XLEN(XLEN), .RESET_PC(RESET_PC)) u_fetch (
    .i_fetch_stage_clk(i_riscv_core_clk), .i_rst_n(i_rst_n),
    .i_stall_f(stall_f), .i_stall_d(stall_d), .i_flush_d(flush_d),
    .i_pcsrc_e(pcsrc_e), .i_target_e(target_e), .i_inst(i_inst),
    .o_pc(o_pc), .o_inst_d(inst_d), .o_pc_d(pc_d)
  );

  decode_stage #(.XLEN(XLEN)) u_decode (
    .i_decode_stage_clk(i_riscv_core_clk), .i_rst_n(i_rst_n),
    .i_stall_d(stall_d), .i_flush_e(flush_e), .i_inst_d(inst_d), .i_pc_d(pc_d),
    .i_regw_w(regw_w), .i_rd_w(rd_w), .i_result_w(result_w),
    .o_rs1_d(rs1_d), .o_rs2_d(rs2_d), .o_rs1_e(rs1_e), .o_rs2_e(rs2_e), .o_rd_e(rd_e),
    .o_rdata1_e(rdata1_e), .o_rdata2_e(rdata2_e), .o_imm_e(imm_e), .o_pc_e(pc_e),
    .o_aluop_e(aluop_e), .o_bsel_e(bsel_e), .o_regw_e(regw_e), .o_memr_e(memr_e),
    .o_memw_e(memw_e), .o_branch_e(branch_e), .o_bne_e(bne_e)
  );

  execute_stage #(.XLEN(XLEN)) u_execute (
    .i_execute_stage_clk(i_riscv_core_clk), .i_rst_n(i_rst_n), .i_globstall(o_globstall),
    .i_rs1_e(rs1_e), .i_rs2_e(rs2_e), .i_rd_e(rd_e),
    .i_rdata1_e(rdata1_e), .i_rdata2_e(rdata2_e), .i_imm_e(imm_e), .i_pc_e(pc_e),
    .i_aluop_e(aluop_e), .i_bsel_e(bsel_e), .i_regw_e(regw_e), .i_memr_e(memr_e),
    .i_memw_e(memw_e), .i_branch_e(branch_e), .i_bne_e(bne_e),
    .i_fwd_a(fwd_a), .i_fwd_b(fwd_b), .i_result_w(result_w),
    .o_pcsrc_e(pcsrc_e), .o_target_e(target_e), .o_alu_m(alu_m), .o_store_m(store_m),
    .o_rd_m(rd_m), .o_regw_m(regw_m), .o_memr_m(memr_m), .o_memw_m(memw_m)
  );

  memory_stage #(.XLEN(XLEN)) u_memory (
    .i_memory_stage_clk(i_riscv_core_clk), .i_rst_n(i_rst_n), .i_globstall(o_globstall),
    .i_memr_m(memr_m), .i_memw_m(memw_m), .i_regw_m(regw_m),
    .i_alu_m(alu_m), .i_store_m(store_m), .i_rdata(i_rdata), .i_rd_m(rd_m),
    .o_mem_addr(o_mem_addr), .o_store_data(o_store_data),
    .o_memr(o_memr_m), .o_memw(o_memw_m),
    .o_regw_w(regw_w), .o_rd_w(rd_w), .o_result_w(result_w)
  );

  hazard_unit u_hazard (
    .i_hazard_unit_clk(i_riscv_core_clk),
    .i_rs1_d(rs1_d), .i_rs2_d(rs2_d), .i_rs1_e(rs1_e), .i_rs2_e(rs2_e),
    .i_rd_e(rd_e), .i_rd_m(rd_m), .i_rd_w(rd_w),
    .i_memr_e(memr_e), .i_regw_m(regw_m), .i_regw_w(regw_w),
    .i_pcsrc_e(pcsrc_e), .i_stall_dm(i_stall_dm),
    .o_fwd_a(fwd_a), .o_fwd_b(fwd_b), .o_stall_f(stall_f), .o_stall_d(stall_d),
    .o_flush_d(flush_d), .o_flush_e(flush_e), .o_globstall(o_globstall)
  );

endmodule

// File: tb_riscv_core.sv
`timescale 1ns/1ps

module tb_riscv_core;
  import core_pkg::*;

  localparam int              XLEN       = 64;
  localparam logic [XLEN-1:0] RESET_PC   = '0;
  localparam int              WBYTES     = XLEN / 8;
  localparam int              PROG_LEN   = 35;
  localparam int              NUM_STORES = 9;
  localparam int              DMEM_WORDS = 32;
  localparam logic [2:0]      F3_ADD = 3'b000, F3_SLT = 3'b010, F3_SLTU = 3'b011;
  localparam logic [2:0]      F3_XOR = 3'b100, F3_OR = 3'b110, F3_AND = 3'b111;
  localparam logic [2:0]      F3_WORD = (XLEN == 64) ? 3'b011 : 3'b010;  // ld/sd or lw/sw

  logic            clk;
  logic            rst_n;
  inst_u           inst;
  logic [XLEN-1:0] rdata;
  logic            stall_dm;
  logic [XLEN-1:0] pc;
  logic            memr;
  logic            memw;
  logic [XLEN-1:0] mem_addr;
  logic [XLEN-1:0] store_data;
  logic            globstall;

  inst_u             prog [PROG_LEN];
  logic [2*XLEN-1:0] exp_store [NUM_STORES];         // {address, data}
  logic [XLEN-1:0]   dmem [DMEM_WORDS];
  integer            seed;
  int                store_idx, cycles, stall_cycles, fail_count, pass_no;
  logic              running, random_stall;
  logic              prev_hold, prev_memr, prev_memw;
  logic [XLEN-1:0]   prev_addr, prev_data;

  riscv_core #(.XLEN(XLEN), .RESET_PC(RESET_PC)) UUT (
    .i_riscv_core_clk(clk), .i_rst_n(rst_n), .i_inst(inst), .i_rdata(rdata),
    .i_stall_dm(stall_dm), .o_pc(pc), .o_memr_m(memr), .o_memw_m(memw),
    .o_mem_addr(mem_addr), .o_store_data(store_data), .o_globstall(globstall)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  function automatic inst_u alu_reg_inst(logic [2:0] f3, logic sub, reg_addr_t rd,
                                         reg_addr_t rs1, reg_addr_t rs2);
    inst_u w;
    w = '0;
    w.r.funct7 = {1'b0, sub, 5'b0};
    w.r.rs2    = rs2;
    w.r.rs1    = rs1;
    w.r.funct3 = f3;
    w.r.rd     = rd;
    w.r.opcode = OP_REG;
    return w;
  endfunction

  function automatic inst_u alu_imm_inst(logic [2:0] f3, reg_addr_t rd, reg_addr_t rs1,
                                         int imm);
    inst_u w;
    w = '0;
    w.i.imm12  = imm[11:0];
    w.i.rs1    = rs1;
    w.i.funct3 = f3;
    w.i.rd     = rd;
    w.i.opcode = OP_IMM;
    return w;
  endfunction

  function automatic inst_u load_inst(reg_addr_t rd, reg_addr_t rs1, int imm);
    inst_u w;
    w = alu_imm_inst(F3_WORD, rd, rs1, imm);
    w.i.opcode = OP_LOAD;
    return w;
  endfunction

  function automatic inst_u store_inst(reg_addr_t rs2, reg_addr_t rs1, int imm);
    inst_u w;
    w = '0;
    w.s.imm_hi = imm[11:5];
    w.s.rs2    = rs2;
    w.s.rs1    = rs1;
    w.s.funct3 = F3_WORD;
    w.s.imm_lo = imm[4:0];
    w.s.opcode = OP_STORE;
    return w;
  endfunction

  function automatic inst_u branch_inst(logic is_bne, reg_addr_t rs1, reg_addr_t rs2, int imm);
    inst_u w;
    w = '0;
    w.b.imm12   = imm[12];
    w.b.imm10_5 = imm[10:5];
    w.b.rs2     = rs2;
    w.b.rs1     = rs1;
    w.b.funct3  = {2'b00, is_bne};
    w.b.imm4_1  = imm[4:1];
    w.b.imm11   = imm[11];
    w.b.opcode  = OP_BRANCH;
    return w;
  endfunction

  // odd multiplier spreads every address bit over the word
  function automatic logic [XLEN-1:0] fill_word(logic [XLEN-1:0] addr);
    logic [63:0] h;
    h = (64'(addr) ^ 64'h5a5a_0f0f_3c3c_9696) * 64'h9e37_79b9_7f4a_7c15;
    return h[XLEN-1:0];
  endfunction

  task automatic abort_run();
    fail_count++;
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_addr(string name, logic [XLEN-1:0] act, logic [XLEN-1:0] exp);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_data(string name, logic [XLEN-1:0] act, logic [XLEN-1:0] exp);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic check_flag(string name, logic act, logic exp);
    if (act !== exp) begin
      $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, act, exp);
      abort_run();
    end
  endtask

  task automatic load_program();
    prog[0]  = alu_imm_inst(F3_ADD, 1, 0, 5);          // x1 = 5
    prog[1]  = alu_imm_inst(F3_ADD, 2, 0, -3);         // x2 = -3
    prog[2]  = alu_reg_inst(F3_ADD, 0, 3, 1, 2);       // x3 = 2, both operands forwarded
    prog[3]  = alu_reg_inst(F3_ADD, 1, 4, 3, 1);       // sub, x4 = -3
    prog[4]  = store_inst(4, 0, 8);
    prog[5]  = alu_reg_inst(F3_SLT, 0, 5, 4, 3);       // x5 = 1
    prog[6]  = alu_reg_inst(F3_SLTU, 0, 6, 4, 3);      // x6 = 0
    prog[7]  = alu_reg_inst(F3_XOR, 0, 7, 5, 4);       // x7 = -4
    prog[8]  = alu_reg_inst(F3_OR, 0, 8, 7, 6);        // x8 = -4
    prog[9]  = alu_reg_inst(F3_AND, 0, 9, 8, 1);       // x9 = 4
    prog[10] = alu_imm_inst(F3_ADD, 0, 1, 7);          // write to x0 is dropped
    prog[11] = alu_reg_inst(F3_ADD, 0, 10, 0, 9);      // x10 = 4
    prog[12] = store_inst(10, 0, 16);
    prog[13] = store_inst(5, 0, 24);
    prog[14] = store_inst(6, 0, 32);
    prog[15] = store_inst(8, 0, 40);
    prog[16] = alu_imm_inst(F3_XOR, 11, 9, 12'h7ff);   // x11 = 2043
    prog[17] = alu_imm_inst(F3_AND, 12, 11, 12'h0f0);  // x12 = 240
    prog[18] = alu_imm_inst(F3_OR, 13, 12, 3);         // x13 = 243
    prog[19] = alu_imm_inst(F3_SLT, 14, 2, -2);        // x14 = 1
    prog[20] = alu_imm_inst(F3_SLTU, 15, 2, -2);       // x15 = 1
    prog[21] = alu_reg_inst(F3_ADD, 0, 16, 13, 14);
    prog[22] = alu_reg_inst(F3_ADD, 0, 16, 16, 15);    // x16 = 245
    prog[23] = store_inst(16, 0, 48);
    prog[24] = load_inst(17, 0, 64);
    prog[25] = alu_imm_inst(F3_ADD, 18, 17, 100);      // load-use bubble here
    prog[26] = store_inst(18, 0, 56);
    prog[27] = branch_inst(1'b0, 1, 1, 12);            // beq taken to 30
    prog[28] = store_inst(1, 0, 72);
    prog[29] = store_inst(2, 0, 80);
    prog[30] = branch_inst(1'b1, 1, 1, 8);             // bne not taken
    prog[31] = store_inst(1, 0, 88);
    prog[32] = branch_inst(1'b1, 1, 2, 8);             // bne taken to 34
    prog[33] = store_inst(2, 0, 96);
    prog[34] = store_inst(9, 0, 104);
    exp_store[0] = {XLEN'(8), XLEN'(-3)};
    exp_store[1] = {XLEN'(16), XLEN'(4)};
    exp_store[2] = {XLEN'(24), XLEN'(1)};
    exp_store[3] = {XLEN'(32), XLEN'(0)};
    exp_store[4] = {XLEN'(40), XLEN'(-4)};
    exp_store[5] = {XLEN'(48), XLEN'(245)};
    exp_store[6] = {XLEN'(56), fill_word(XLEN'(64)) + XLEN'(100)};
    exp_store[7] = {XLEN'(88), XLEN'(5)};
    exp_store[8] = {XLEN'(104), XLEN'(4)};
  endtask

  task automatic run_pass();
    for (int i = 0; i < DMEM_WORDS; i++) dmem[i] = fill_word(XLEN'(i * WBYTES));
    store_idx    = 0;
    cycles       = 0;
    stall_cycles = 0;
    rst_n        = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    check_addr("o_pc", pc, RESET_PC);
    check_flag("o_memr_m", memr, 1'b0);
    check_flag("o_memw_m", memw, 1'b0);
    rst_n   = 1'b1;
    running = 1'b1;
    while (store_idx < NUM_STORES) @(posedge clk);
    repeat (8) @(posedge clk);                       // catch stray stores
    #1;
    running = 1'b0;
  endtask

  // instruction and data memory answer in the cycle of the request
  always @(posedge clk) begin
    #1;
    if (pc < XLEN'(PROG_LEN * 4)) inst = prog[pc >> 2];
    else inst = 32'h0000_0013;                       // addi x0, x0, 0
    if (memr && mem_addr / WBYTES >= DMEM_WORDS) begin
      $display("Load at %0t ns from address %h outside the data memory", $time, mem_addr);
      abort_run();
    end
    if (memr) rdata = dmem[(mem_addr / WBYTES) % DMEM_WORDS];
    else rdata = 'x;                                 // no read requested
    if (random_stall) stall_dm = ($random(seed) & 3) == 0;
    else stall_dm = 1'b0;
  end

  always @(posedge clk) begin
    if (running) begin
      cycles++;
      if (stall_dm) stall_cycles++;
      if (cycles > 4 * PROG_LEN + stall_cycles + 50) begin
        $display("Timeout in pass %0d after %0d cycles, %0d of %0d stores seen",
                 pass_no, cycles, store_idx, NUM_STORES);
        abort_run();
      end
    end
  end

  // sampled mid-cycle because a store completes at the next edge when not stalled
  always @(negedge clk) begin
    if (!running) begin
      prev_hold = 1'b0;
    end else begin
      check_flag("o_globstall", globstall, stall_dm);
      if (prev_hold) begin
        check_flag("o_memr_m", memr, prev_memr);
        check_flag("o_memw_m", memw, prev_memw);
        check_addr("o_mem_addr", mem_addr, prev_addr);
        check_data("o_store_data", store_data, prev_data);
      end
      if (memw && !stall_dm) begin
        if (store_idx >= NUM_STORES) begin
          $display("Unexpected store at %0t ns to address %h", $time, mem_addr);
          abort_run();
        end
        check_addr("o_mem_addr", mem_addr, exp_store[store_idx][2*XLEN-1:XLEN]);
        check_data("o_store_data", store_data, exp_store[store_idx][XLEN-1:0]);
        dmem[mem_addr / WBYTES] = store_data;
        store_idx++;
      end
      prev_hold = stall_dm && (memr || memw);
      prev_memr = memr;
      prev_memw = memw;
      prev_addr = mem_addr;
      prev_data = store_data;
    end
  end

  initial begin
    rst_n        = 1'b0;
    inst         = 32'h0000_0013;
    rdata        = '0;
    stall_dm     = 1'b0;
    running      = 1'b0;
    random_stall = 1'b0;
    prev_hold    = 1'b0;
    fail_count   = 0;
    seed         = 32'h49bb_42cc;
    load_program();
    for (pass_no = 0; pass_no < 2; pass_no++) begin
      random_stall = (pass_no == 1);                 // second pass under random memory stalls
      run_pass();
    end
    if (fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule
